// File: div_pkg.sv
package div_pkg;

    parameter int default_width = 16;

    // controller states
    typedef enum logic [2:0] {
        idle          = 3'd0,
        loading       = 3'd1,
        check_divisor = 3'd2,
        divide        = 3'd3,
        sub           = 3'd4,
        shift_left    = 3'd5,
        done          = 3'd6
    } div_state_t;

    // strobes from control unit to datapath
    typedef struct packed {
        logic ld;       // capture operands, clear step counter
        logic sub_en;   // subtract divisor, set quotient lsb
        logic shift_en; // shift remainder/quotient pair, count step
    } div_ctrl_t;

    // flags from datapath back to control unit
    typedef struct packed {
        logic dvz;      // divisor is zero
        logic ovf;      // upper dividend half >= divisor
        logic gt;       // partial remainder >= divisor
        logic cnt_done; // last iteration
    } div_status_t;

    // error pulse at the top level
    typedef struct packed {
        logic dvz;
        logic ovf;
    } div_err_t;

endpackage

// File: div_control.sv
`timescale 1ns/10ps

module div_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  div_pkg::div_status_t   status,
    output div_pkg::div_ctrl_t     ctrl,
    output logic                   busy,
    output logic                   valid,
    output div_pkg::div_err_t      error
);

    div_pkg::div_state_t state;
    div_pkg::div_state_t next_state;

    logic abort; // operand check failed

    assign abort = (state == div_pkg::check_divisor) && (status.dvz || status.ovf);

    always_comb begin
        next_state = state;
        unique case (state)
            div_pkg::idle: begin
                if (start) begin
                    next_state = div_pkg::loading;
                end
            end
            div_pkg::loading: begin
                next_state = div_pkg::check_divisor;
            end
            div_pkg::check_divisor: begin
                if (abort) begin
                    next_state = div_pkg::idle;
                end else begin
                    next_state = div_pkg::divide;
                end
            end
            div_pkg::divide: begin
                // restore step only when it fits
                if (status.gt) begin
                    next_state = div_pkg::sub;
                end else begin
                    next_state = div_pkg::shift_left;
                end
            end
            div_pkg::sub: begin
                next_state = div_pkg::shift_left;
            end
            div_pkg::shift_left: begin
                if (status.cnt_done) begin
                    next_state = div_pkg::done;
                end else begin
                    next_state = div_pkg::divide;
                end
            end
            div_pkg::done: begin
                next_state = div_pkg::idle;
            end
            default: begin
                next_state = div_pkg::idle;
            end
        endcase
    end

    // strobes straight from the state
    always_comb begin
        ctrl          = '0;
        ctrl.ld       = (state == div_pkg::loading);
        ctrl.sub_en   = (state == div_pkg::sub);
        // last iteration leaves the remainder in place
        ctrl.shift_en = (state == div_pkg::shift_left) && !status.cnt_done;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= div_pkg::idle;
            busy  <= 1'b0;
            valid <= 1'b0;
            error <= '0;
        end else begin
            state     <= next_state;
            busy      <= (next_state != div_pkg::idle) && (next_state != div_pkg::done);
            valid     <= (state == div_pkg::shift_left) && status.cnt_done;
            error.dvz <= abort && status.dvz;
            error.ovf <= abort && !status.dvz; // dvz wins
        end
    end

    // result and error never coincide
    a_valid_err_excl: assert property (
        @(posedge clk) disable iff (reset)
        !(valid && (error.dvz || error.ovf))
    );

    // load strobe only right after an accepted start
    a_ld_in_loading: assert property (
        @(posedge clk) disable iff (reset)
        ctrl.ld |-> busy && !$past(busy) && $past(start)
    );

    // busy already dropped when the result shows up
    a_busy_low_valid: assert property (
        @(posedge clk) disable iff (reset)
        valid |-> !busy && $past(busy)
    );

endmodule

// File: div_datapath.sv
`timescale 1ns/10ps

module div_datapath #(
    parameter int WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    input  div_pkg::div_ctrl_t     ctrl,
    input  logic [2*WIDTH-1:0]     dividend,
    input  logic [WIDTH-1:0]       divisor,
    output div_pkg::div_status_t   status,
    output logic [WIDTH-1:0]       quotient,
    output logic [WIDTH-1:0]       remainder
);

    localparam int cnt_w = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic [WIDTH:0]     rem_r;  // partial remainder, one spare bit
    logic [WIDTH-1:0]   quo_r;  // low dividend half shifts out, quotient shifts in
    logic [WIDTH-1:0]   div_r;
    logic [cnt_w-1:0]   cnt_r;
    logic [WIDTH:0]     diff;

    assign diff = rem_r - {1'b0, div_r};

    // operand and shift registers
    always_ff @(posedge clk) begin
        if (ctrl.ld) begin
            div_r          <= divisor;
            // pre-shift so the first compare sees the top bits
            {rem_r, quo_r} <= {dividend, 1'b0};
        end else if (ctrl.sub_en) begin
            rem_r    <= diff;
            quo_r[0] <= 1'b1;
        end else if (ctrl.shift_en) begin
            {rem_r, quo_r} <= {rem_r[WIDTH-1:0], quo_r, 1'b0};
        end
    end

    // step counter
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_r <= '0;
        end else if (ctrl.ld) begin
            cnt_r <= '0;
        end else if (ctrl.shift_en) begin
            cnt_r <= cnt_r + 1'b1;
        end
    end

    always_comb begin
        status          = '0;
        status.dvz      = (div_r == '0);
        // right after load rem_r holds the upper half shifted by one
        status.ovf      = (rem_r[WIDTH:1] >= div_r);
        status.gt       = (rem_r >= {1'b0, div_r});
        status.cnt_done = (cnt_r == cnt_w'(WIDTH - 1));
    end

    assign quotient  = quo_r;
    assign remainder = rem_r[WIDTH-1:0]; // below divisor after the last step

    // remainder stays under twice the divisor, so one subtract always clears gt
    a_rem_bound: assert property (
        @(posedge clk) disable iff (reset)
        ctrl.sub_en |-> status.gt && (diff < {1'b0, div_r}) ##1 !status.gt
    );

endmodule

// File: div_top.sv
`timescale 1ns/10ps

module div_top #(
    parameter int WIDTH = div_pkg::default_width
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic [2*WIDTH-1:0]     dividend,
    input  logic [WIDTH-1:0]       divisor,
    output logic                   busy,
    output logic                   valid,
    output div_pkg::div_err_t      error,
    output logic [WIDTH-1:0]       quotient,
    output logic [WIDTH-1:0]       remainder
);

    div_pkg::div_ctrl_t   ctrl;
    div_pkg::div_status_t status;

    // sequencer
    div_control div_control_i (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .status (status),
        .ctrl   (ctrl),
        .busy   (busy),
        .valid  (valid),
        .error  (error)
    );

    // registers, compare/subtract, counter
    div_datapath #(
        .WIDTH (WIDTH)
    ) div_datapath_i (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .dividend  (dividend),
        .divisor   (divisor),
        .status    (status),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

// File: tb_div_ref.svh
`ifndef TB_DIV_REF_SVH
`define TB_DIV_REF_SVH

// expected outcome of one operation
typedef struct packed {
    div_pkg::div_err_t  err;
    logic [WIDTH-1:0]   q;
    logic [WIDTH-1:0]   r;
} div_result_t;

// zero divisor first, then overflow of the upper half, else plain division
function automatic div_result_t ref_div(input logic [2*WIDTH-1:0] dd,
                                        input logic [WIDTH-1:0] dv);
    div_result_t        res;
    logic [2*WIDTH-1:0] q_full;
    logic [2*WIDTH-1:0] r_full;
    res = '0;
    if (dv == '0) begin
        res.err.dvz = 1'b1;
    end else if (dd[2*WIDTH-1:WIDTH] >= dv) begin
        res.err.ovf = 1'b1; // quotient would not fit
    end else begin
        q_full = dd / dv;
        r_full = dd % dv;
        res.q  = q_full[WIDTH-1:0];
        res.r  = r_full[WIDTH-1:0];
    end
    return res;
endfunction

// 32-bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// File: tb_div.sv
`timescale 1ns/10ps

module tb_div;

    localparam int WIDTH           = 16;
    localparam int n_random        = 200;
    localparam int n_directed      = 12;
    localparam int n_ops           = n_random + n_directed;
    localparam int max_lat         = 3 * WIDTH + 3;
    localparam int min_lat         = 2 * WIDTH + 3;
    localparam int watchdog_cycles = n_ops * (3 * WIDTH + 6) + 16 + 20;

    `include "tb_div_ref.svh"

    logic                 clk;
    logic                 reset;
    logic                 start;
    logic [2*WIDTH-1:0]   dividend;
    logic [WIDTH-1:0]     divisor;
    logic                 busy;
    logic                 valid;
    div_pkg::div_err_t    error;
    logic [WIDTH-1:0]     quotient;
    logic [WIDTH-1:0]     remainder;

    logic [31:0]          lfsr_state = 32'hfa3d_d00d;
    int                   cyc = 0;
    int                   start_cyc = 0;
    bit                   in_flight = 0;
    int                   fails = 0;
    int                   tests = 0;
    int                   valid_count = 0;
    int                   exp_valid_count = 0;
    div_result_t          exp_q[$];
    string                name_q[$];

    div_top #(
        .WIDTH (WIDTH)
    ) div_top_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .dividend  (dividend),
        .divisor   (divisor),
        .busy      (busy),
        .valid     (valid),
        .error     (error),
        .quotient  (quotient),
        .remainder (remainder)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // one operation; poke fires a second start while busy, with other operands
    task automatic run_op(input logic [2*WIDTH-1:0] dd, input logic [WIDTH-1:0] dv,
                          input string name, input bit poke);
        div_result_t e;
        e = ref_div(dd, dv);
        exp_q.push_back(e);
        name_q.push_back(name);
        if (e.err == '0) exp_valid_count++;
        @(posedge clk);
        #2;
        dividend  = dd;
        divisor   = dv;
        start     = 1'b1;
        start_cyc = cyc;
        in_flight = 1'b1;
        @(posedge clk);
        #2 start = 1'b0;
        if (poke) begin
            repeat (3) @(posedge clk);
            #2;
            dividend = ~dd;
            divisor  = dv ^ 16'h5a5a;
            start    = 1'b1;
            @(posedge clk);
            #2 start = 1'b0;
        end
        wait (!in_flight);
    endtask

    // stimulus
    initial begin
        logic [WIDTH-1:0] dv;
        logic [WIDTH-1:0] hi;
        logic [WIDTH-1:0] lo;
        int               i;
        reset    = 1'b1;
        start    = 1'b0;
        dividend = '0;
        divisor  = '0;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;

        for (i = 0; i < n_random; i++) begin
            dv = rand_bits(WIDTH);
            if (dv == '0) dv = 1;
            hi = rand_bits(WIDTH) % dv; // keep the quotient in range
            lo = rand_bits(WIDTH);
            run_op({hi, lo}, dv, "random", (i % 50) == 7);
        end

        run_op(32'h1234_5678, 16'h0000, "divide by zero", 1'b0);
        run_op(32'hffff_ffff, 16'h0000, "divide by zero with overflow", 1'b0);
        run_op(32'h0005_0000, 16'h0005, "overflow equal", 1'b0);
        run_op(32'hffff_0000, 16'h8000, "overflow large", 1'b0);
        run_op(32'h0001_0000, 16'h0001, "overflow divisor one", 1'b0);
        run_op(32'h0000_0000, 16'h1234, "zero dividend", 1'b0);
        run_op(32'h0000_beef, 16'h0001, "divisor one", 1'b0);
        run_op(32'hfffe_ffff, 16'hffff, "largest operands", 1'b0);
        run_op(32'h0000_4321, 16'h4321, "dividend equals divisor", 1'b0);
        run_op(32'h0000_ffff, 16'hffff, "dividend equals max divisor", 1'b0);
        run_op(32'h1234_5678, 16'habcd, "start while busy", 1'b1);
        run_op(32'h0000_ffff, 16'h0003, "start while busy small", 1'b1);

        repeat (10) @(posedge clk); // catch late stray pulses
        assert (valid_count == exp_valid_count) else begin
            $display("valid pulse count is %0d but %0d operations should complete",
                     valid_count, exp_valid_count);
            fails++;
        end
        $display("tests run %0d, checks failed %0d", tests, fails);
        if (fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // compare on the falling edge, outputs settled
    initial begin
        div_result_t e;
        string       name;
        bit          pulse;
        int          k;
        int          fails_before;
        forever begin
            @(negedge clk);
            if (!reset) begin
                pulse = valid || error.dvz || error.ovf;
                if (valid) valid_count++;
                if (pulse) begin
                    assert (in_flight) else begin
                        $display("result or error pulse at %0t with no operation running",
                                 $time);
                        fails++;
                    end
                end
                if (!in_flight) begin
                    assert (!busy) else begin
                        $display("busy high at %0t with no operation running", $time);
                        fails++;
                    end
                end else begin
                    k = cyc - start_cyc;
                    if (pulse) begin
                        e = exp_q.pop_front();
                        name = name_q.pop_front();
                        fails_before = fails;
                        assert (!(valid && (error.dvz || error.ovf))) else begin
                            $display("valid and error high together at %0t", $time);
                            fails++;
                        end
                        assert (!busy) else begin
                            $display("busy still high with the result pulse at %0t", $time);
                            fails++;
                        end
                        if (e.err != '0) begin
                            assert (error == e.err) else begin
                                $display("Mismatch at %0t: error %b, expected %b",
                                         $time, error, e.err);
                                fails++;
                            end
                            assert (k == 3) else begin
                                $display("error pulse in cycle %0d after start, not 3", k);
                                fails++;
                            end
                        end else begin
                            assert (valid) else begin
                                $display("error pulse on an operation that should complete");
                                fails++;
                            end
                            assert (quotient == e.q) else begin
                                $display("Mismatch at %0t: quotient %h, expected %h",
                                         $time, quotient, e.q);
                                fails++;
                            end
                            assert (remainder == e.r) else begin
                                $display("Mismatch at %0t: remainder %h, expected %h",
                                         $time, remainder, e.r);
                                fails++;
                            end
                            assert (k >= min_lat && k <= max_lat) else begin
                                $display("result took %0d cycles, outside %0d to %0d",
                                         k, min_lat, max_lat);
                                fails++;
                            end
                        end
                        $display("test %0d %s: %s", tests, name,
                                 (fails == fails_before) ? "ok" : "failed");
                        tests++;
                        in_flight = 1'b0;
                    end else begin
                        if (k >= 1) begin
                            assert (busy) else begin
                                $display("busy low in cycle %0d of a running operation", k);
                                fails++;
                            end
                        end
                        assert (k <= max_lat) else begin
                            $display("no valid or error pulse within %0d cycles of start",
                                     max_lat);
                            fails++;
                            void'(exp_q.pop_front());
                            name = name_q.pop_front();
                            $display("test %0d %s: failed", tests, name);
                            tests++;
                            in_flight = 1'b0;
                        end
                    end
                end
            end
        end
    end

    // watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("run did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
div_pkg.sv
div_control.sv
div_datapath.sv
div_top.sv
tb_div.sv
